// ==== hw/sat_pkg.sv ====
package sat_pkg;

    localparam int NUM_VARS    = 8;
    localparam int NUM_CLAUSES = 4;
    localparam int CLEN_W      = 4;
    localparam int VAR_W       = $clog2(NUM_VARS);

    // one literal of a clause; both bits clear means the variable is absent.
    typedef struct packed {
        logic pos;
        logic neg;
    } lit_t;

    // implied marks a value that came from propagation.
    typedef struct packed {
        logic assigned;
        logic value;
        logic implied;
    } var_state_t;

    typedef lit_t [NUM_VARS-1:0] clause_t;

    typedef var_state_t [NUM_VARS-1:0] var_vec_t;

    // saturating free-literal count.
    typedef logic [1:0] fcnt_t;

    localparam fcnt_t FCNT_ZERO = 2'd0;
    localparam fcnt_t FCNT_ONE  = 2'd1;
    localparam fcnt_t FCNT_MANY = 2'd2;

    localparam lit_t LIT_ABSENT = '{pos: 1'b0, neg: 1'b0};

    localparam var_state_t VAR_FREE = '{assigned: 1'b0, value: 1'b0, implied: 1'b0};

endpackage

// ==== hw/lit_cell.sv ====
`timescale 1ns/1ps

module lit_cell (
    input  logic                clk,
    input  logic                rst,
    input  sat_pkg::lit_t       lit_i,
    input  logic                wr_i,
    input  sat_pkg::var_state_t var_i,
    output sat_pkg::var_state_t var_o,
    input  sat_pkg::fcnt_t      fcnt_pre_i,
    output sat_pkg::fcnt_t      fcnt_next_o,
    input  logic                imp_drv_i,
    input  logic                apply_impl_i,
    output logic                sat_o,
    output logic                cclause_o,
    output sat_pkg::lit_t       lit_o
);
    import sat_pkg::*;

    lit_t lit_r;
    logic imp_me_r;
    logic present;
    logic free;
    logic driving;

    assign present = lit_r.pos | lit_r.neg;
    assign free    = present & ~var_i.assigned;
    assign driving = imp_drv_i & free;

    always_ff @(posedge clk) begin
        if (!rst) begin
            lit_r <= LIT_ABSENT;
        end else if (wr_i) begin
            lit_r <= lit_i;
        end
    end

    // remembers that this cell produced the pending implication.
    always_ff @(posedge clk) begin
        if (!rst) begin
            imp_me_r <= 1'b0;
        end else if (wr_i) begin
            imp_me_r <= 1'b0;
        end else if (apply_impl_i && driving) begin
            imp_me_r <= 1'b1;
        end
    end

    assign sat_o = present & var_i.assigned & (var_i.value ? lit_r.pos : lit_r.neg);

    assign fcnt_next_o = !free                   ? fcnt_pre_i :
                         (fcnt_pre_i == FCNT_ZERO) ? FCNT_ONE   : FCNT_MANY;

    // implied value equals the literal polarity.
    assign var_o = driving ? '{assigned: 1'b1, value: lit_r.pos, implied: 1'b1} : VAR_FREE;

    // the variable this cell implied has been released again by a backtrack.
    assign cclause_o = imp_me_r & ~var_i.assigned;

    assign lit_o = lit_r;

endmodule

// ==== hw/lit_row.sv ====
`timescale 1ns/1ps

module lit_row (
    input  logic              clk,
    input  logic              rst,
    input  logic              wr_i,
    input  sat_pkg::clause_t  clause_i,
    output sat_pkg::clause_t  clause_o,
    input  sat_pkg::var_vec_t var_vec_i,
    output sat_pkg::var_vec_t var_vec_o,
    input  logic              imp_drv_i,
    input  logic              apply_impl_i,
    output sat_pkg::fcnt_t    fcnt_o,
    output logic              sat_o,
    output logic              cclause_o
);
    import sat_pkg::*;

    fcnt_t                fcnt_chain [NUM_VARS+1];
    logic [NUM_VARS-1:0]  sat_bits;
    logic [NUM_VARS-1:0]  cclause_bits;

    // count starts empty at the head of the row.
    assign fcnt_chain[0] = FCNT_ZERO;

    for (genvar v = 0; v < NUM_VARS; v++) begin : g_cell
        lit_cell u_lit_cell (
            .clk          (clk),
            .rst          (rst),
            .lit_i        (clause_i[v]),
            .wr_i         (wr_i),
            .var_i        (var_vec_i[v]),
            .var_o        (var_vec_o[v]),
            .fcnt_pre_i   (fcnt_chain[v]),
            .fcnt_next_o  (fcnt_chain[v+1]),
            .imp_drv_i    (imp_drv_i),
            .apply_impl_i (apply_impl_i),
            .sat_o        (sat_bits[v]),
            .cclause_o    (cclause_bits[v]),
            .lit_o        (clause_o[v])
        );
    end

    assign fcnt_o    = fcnt_chain[NUM_VARS];
    assign sat_o     = |sat_bits;
    assign cclause_o = |cclause_bits;

endmodule

// ==== hw/terminal_cell.sv ====
`timescale 1ns/1ps

module terminal_cell (
    input  logic           clausesat_i,
    input  sat_pkg::fcnt_t fcnt_i,
    input  logic           cclause_i,
    output logic           imp_drv_o,
    output logic           conflict_o,
    output logic           cclause_drv_o
);
    import sat_pkg::*;

    logic unsat;

    assign unsat = ~clausesat_i;

    // unit clause, the one free literal must become true.
    assign imp_drv_o = unsat & (fcnt_i == FCNT_ONE);

    // no free literal left and nothing true; an empty clause lands here too.
    assign conflict_o = unsat & (fcnt_i == FCNT_ZERO);

    // clear request only counts while the clause is open again.
    assign cclause_drv_o = cclause_i & (unsat | imp_drv_o);

endmodule

// ==== hw/clause_cell.sv ====
`timescale 1ns/1ps

module clause_cell (
    input  logic                      clk,
    input  logic                      rst,
    input  sat_pkg::var_vec_t         var_vec_i,
    output sat_pkg::var_vec_t         var_vec_o,
    input  logic                      wr_i,
    input  logic                      rd_i,
    input  sat_pkg::clause_t          clause_i,
    output sat_pkg::clause_t          clause_o,
    input  logic [sat_pkg::CLEN_W-1:0] clause_len_i,
    output logic [sat_pkg::CLEN_W-1:0] clause_len_o,
    input  logic                      apply_impl_i,
    input  logic                      apply_bkt_i,
    output logic                      sat_o,
    output logic                      conflict_o
);
    import sat_pkg::*;

    clause_t           lits;
    fcnt_t             fcnt;
    logic              clausesat;
    logic              cclause;
    logic              cclause_drv;
    logic              imp_drv;
    logic              is_reason_r;
    logic              need_clear_r;
    logic [CLEN_W-1:0] len_r;

    lit_row u_lit_row (
        .clk          (clk),
        .rst          (rst),
        .wr_i         (wr_i),
        .clause_i     (clause_i),
        .clause_o     (lits),
        .var_vec_i    (var_vec_i),
        .var_vec_o    (var_vec_o),
        .imp_drv_i    (imp_drv),
        .apply_impl_i (apply_impl_i),
        .fcnt_o       (fcnt),
        .sat_o        (clausesat),
        .cclause_o    (cclause)
    );

    terminal_cell u_terminal_cell (
        .clausesat_i   (clausesat),
        .fcnt_i        (fcnt),
        .cclause_i     (cclause),
        .imp_drv_o     (imp_drv),
        .conflict_o    (conflict_o),
        .cclause_drv_o (cclause_drv)
    );

    always_ff @(posedge clk) begin
        if (!rst) begin
            need_clear_r <= 1'b0;
        end else if (is_reason_r && cclause_drv) begin
            need_clear_r <= 1'b1;
        end else if (!is_reason_r) begin
            need_clear_r <= 1'b0;
        end
    end

    // set when this clause's implication is committed.
    always_ff @(posedge clk) begin
        if (!rst) begin
            is_reason_r <= 1'b0;
        end else if (apply_impl_i && imp_drv) begin
            is_reason_r <= 1'b1;
        end else if (apply_bkt_i && need_clear_r) begin
            is_reason_r <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            len_r <= '0;
        end else if (wr_i) begin
            len_r <= clause_len_i;
        end
    end

    assign clause_len_o = is_reason_r ? '0 : len_r;
    assign clause_o     = rd_i ? lits : '0;
    assign sat_o        = clausesat;

endmodule

// ==== hw/clause_array.sv ====
`timescale 1ns/1ps

module clause_array (
    input  logic                                                  clk,
    input  logic                                                  rst,
    input  sat_pkg::var_vec_t                                     var_vec_i,
    output sat_pkg::var_vec_t                                     imp_vec_o,
    input  logic [sat_pkg::NUM_CLAUSES-1:0]                       clause_wr_i,
    input  logic [sat_pkg::NUM_CLAUSES-1:0]                       clause_rd_i,
    input  sat_pkg::clause_t                                      clause_i,
    output sat_pkg::clause_t                                      clause_o,
    input  logic [sat_pkg::CLEN_W-1:0]                            clause_len_i,
    output logic [sat_pkg::NUM_CLAUSES-1:0][sat_pkg::CLEN_W-1:0]  clause_len_o,
    input  logic                                                  apply_impl_i,
    input  logic                                                  apply_bkt_i,
    output logic                                                  all_sat_o,
    output logic                                                  conflict_o
);
    import sat_pkg::*;

    var_vec_t                 imp_req [NUM_CLAUSES];
    clause_t                  rd_data [NUM_CLAUSES];
    logic [NUM_CLAUSES-1:0]   sat_bits;
    logic [NUM_CLAUSES-1:0]   conflict_bits;

    for (genvar c = 0; c < NUM_CLAUSES; c++) begin : g_clause
        clause_cell u_clause_cell (
            .clk          (clk),
            .rst          (rst),
            .var_vec_i    (var_vec_i),
            .var_vec_o    (imp_req[c]),
            .wr_i         (clause_wr_i[c]),
            .rd_i         (clause_rd_i[c]),
            .clause_i     (clause_i),
            .clause_o     (rd_data[c]),
            .clause_len_i (clause_len_i),
            .clause_len_o (clause_len_o[c]),
            .apply_impl_i (apply_impl_i),
            .apply_bkt_i  (apply_bkt_i),
            .sat_o        (sat_bits[c]),
            .conflict_o   (conflict_bits[c])
        );
    end

    // unselected clauses return zero, so a plain OR merges them.
    always_comb begin
        imp_vec_o = '0;
        clause_o  = '0;
        for (int c = 0; c < NUM_CLAUSES; c++) begin
            imp_vec_o = imp_vec_o | imp_req[c];
            clause_o  = clause_o | rd_data[c];
        end
    end

    assign all_sat_o  = &sat_bits;
    assign conflict_o = |conflict_bits;

endmodule

// ==== hw/var_store.sv ====
`timescale 1ns/1ps

module var_store (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      dec_wr_i,
    input  logic [sat_pkg::VAR_W-1:0] dec_var_i,
    input  logic                      dec_val_i,
    input  sat_pkg::var_vec_t         imp_vec_i,
    input  logic                      apply_impl_i,
    input  logic                      apply_bkt_i,
    output sat_pkg::var_vec_t         var_vec_o
);
    import sat_pkg::*;

    var_vec_t vars_r;
    var_vec_t vars_next;

    always_comb begin
        vars_next = vars_r;
        // backtrack drops every implied variable, decisions stay.
        if (apply_bkt_i) begin
            for (int v = 0; v < NUM_VARS; v++) begin
                if (vars_r[v].implied) begin
                    vars_next[v] = VAR_FREE;
                end
            end
        end
        // only still-unassigned variables take an implication.
        if (apply_impl_i) begin
            for (int v = 0; v < NUM_VARS; v++) begin
                if (imp_vec_i[v].assigned && !vars_r[v].assigned) begin
                    vars_next[v] = imp_vec_i[v];
                end
            end
        end
        if (dec_wr_i) begin
            vars_next[dec_var_i] = '{assigned: 1'b1, value: dec_val_i, implied: 1'b0};
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            vars_r <= '0;
        end else begin
            vars_r <= vars_next;
        end
    end

    assign var_vec_o = vars_r;

endmodule

// ==== hw/sat_bcp_top.sv ====
`timescale 1ns/1ps

module sat_bcp_top (
    input  logic                                                  clk,
    input  logic                                                  rst,
    input  logic [sat_pkg::NUM_CLAUSES-1:0]                       clause_wr_i,
    input  logic [sat_pkg::NUM_CLAUSES-1:0]                       clause_rd_i,
    input  sat_pkg::clause_t                                      clause_i,
    input  logic [sat_pkg::CLEN_W-1:0]                            clause_len_i,
    output sat_pkg::clause_t                                      clause_o,
    output logic [sat_pkg::NUM_CLAUSES-1:0][sat_pkg::CLEN_W-1:0]  clause_len_o,
    input  logic                                                  dec_wr_i,
    input  logic [sat_pkg::VAR_W-1:0]                             dec_var_i,
    input  logic                                                  dec_val_i,
    input  logic                                                  apply_impl_i,
    input  logic                                                  apply_bkt_i,
    output sat_pkg::var_vec_t                                     var_vec_o,
    output logic                                                  all_sat_o,
    output logic                                                  conflict_o
);
    import sat_pkg::*;

    var_vec_t var_vec;
    var_vec_t imp_vec;

    clause_array u_clause_array (
        .clk          (clk),
        .rst          (rst),
        .var_vec_i    (var_vec),
        .imp_vec_o    (imp_vec),
        .clause_wr_i  (clause_wr_i),
        .clause_rd_i  (clause_rd_i),
        .clause_i     (clause_i),
        .clause_o     (clause_o),
        .clause_len_i (clause_len_i),
        .clause_len_o (clause_len_o),
        .apply_impl_i (apply_impl_i),
        .apply_bkt_i  (apply_bkt_i),
        .all_sat_o    (all_sat_o),
        .conflict_o   (conflict_o)
    );

    var_store u_var_store (
        .clk          (clk),
        .rst          (rst),
        .dec_wr_i     (dec_wr_i),
        .dec_var_i    (dec_var_i),
        .dec_val_i    (dec_val_i),
        .imp_vec_i    (imp_vec),
        .apply_impl_i (apply_impl_i),
        .apply_bkt_i  (apply_bkt_i),
        .var_vec_o    (var_vec)
    );

    assign var_vec_o = var_vec;

endmodule

// ==== tb/tb_sat_bcp.sv ====
`timescale 1ns/1ps

module tb_sat_bcp;
    import sat_pkg::*;

    localparam int CLK_PERIOD  = 8;
    localparam int NUM_TESTS   = 6;
    localparam int TEST_CYCLES = 500;
    localparam int RAND_ROUNDS = 12;
    localparam int RAND_DECS   = 6;

    logic                               clk;
    logic                               rst;
    logic [NUM_CLAUSES-1:0]             clause_wr_i;
    logic [NUM_CLAUSES-1:0]             clause_rd_i;
    clause_t                            clause_i;
    logic [CLEN_W-1:0]                  clause_len_i;
    clause_t                            clause_o;
    logic [NUM_CLAUSES-1:0][CLEN_W-1:0] clause_len_o;
    logic                               dec_wr_i;
    logic [VAR_W-1:0]                   dec_var_i;
    logic                               dec_val_i;
    logic                               apply_impl_i;
    logic                               apply_bkt_i;
    var_vec_t                           var_vec_o;
    logic                               all_sat_o;
    logic                               conflict_o;

    // reference model of the clause store and the assignment.
    clause_t           model_cl     [NUM_CLAUSES];
    logic [CLEN_W-1:0] model_len    [NUM_CLAUSES];
    logic              model_reason [NUM_CLAUSES];
    var_vec_t          model_vars;

    logic [31:0] rng;
    int          checks;
    int          errors;
    int          tests_done;
    int          err_base;

    sat_bcp_top dut_i (
        .clk          (clk),
        .rst          (rst),
        .clause_wr_i  (clause_wr_i),
        .clause_rd_i  (clause_rd_i),
        .clause_i     (clause_i),
        .clause_len_i (clause_len_i),
        .clause_o     (clause_o),
        .clause_len_o (clause_len_o),
        .dec_wr_i     (dec_wr_i),
        .dec_var_i    (dec_var_i),
        .dec_val_i    (dec_val_i),
        .apply_impl_i (apply_impl_i),
        .apply_bkt_i  (apply_bkt_i),
        .var_vec_o    (var_vec_o),
        .all_sat_o    (all_sat_o),
        .conflict_o   (conflict_o)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(NUM_TESTS * TEST_CYCLES * CLK_PERIOD + 50 * CLK_PERIOD);
        $display("watchdog: the run did not finish within its time budget");
        $display("TB FAILED");
        $finish;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic next_rand(output logic [31:0] r);
        rng = xorshift(rng);
        r = rng;
    endtask

    // two random bits per variable, the pattern 11 becomes an absent literal.
    function automatic clause_t random_clause(input logic [31:0] r);
        clause_t cl;
        for (int v = 0; v < NUM_VARS; v++) begin
            cl[v] = (r[2*v +: 2] == 2'b11) ? LIT_ABSENT : lit_t'(r[2*v +: 2]);
        end
        return cl;
    endfunction

    function automatic clause_t make_clause(input logic [NUM_VARS-1:0] pos_m,
                                            input logic [NUM_VARS-1:0] neg_m);
        clause_t cl;
        for (int v = 0; v < NUM_VARS; v++) begin
            cl[v] = '{pos: pos_m[v], neg: neg_m[v]};
        end
        return cl;
    endfunction

    function automatic logic [CLEN_W-1:0] lit_count(input clause_t cl);
        logic [CLEN_W-1:0] n;
        n = '0;
        for (int v = 0; v < NUM_VARS; v++) begin
            if (cl[v].pos || cl[v].neg) begin
                n = n + 1'b1;
            end
        end
        return n;
    endfunction

    function automatic void eval_clause(input clause_t cl, input var_vec_t vv,
                                        output logic sat, output int cnt);
        sat = 1'b0;
        cnt = 0;
        for (int v = 0; v < NUM_VARS; v++) begin
            if (cl[v].pos || cl[v].neg) begin
                if (!vv[v].assigned) begin
                    cnt++;
                end else if (vv[v].value ? cl[v].pos : cl[v].neg) begin
                    sat = 1'b1;
                end
            end
        end
    endfunction

    // unit clauses force their free literal true.
    function automatic var_vec_t model_requests(input var_vec_t vv);
        var_vec_t req;
        logic     sat;
        int       cnt;
        req = '0;
        for (int c = 0; c < NUM_CLAUSES; c++) begin
            eval_clause(model_cl[c], vv, sat, cnt);
            for (int v = 0; v < NUM_VARS; v++) begin
                if (!sat && cnt == 1 && (model_cl[c][v].pos || model_cl[c][v].neg)
                    && !vv[v].assigned) begin
                    req[v] = '{assigned: 1'b1, value: model_cl[c][v].pos, implied: 1'b1};
                end
            end
        end
        return req;
    endfunction

    task automatic check_hex(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("FAIL %s: got 0x%0h, expected 0x%0h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_state();
        logic exp_all_sat;
        logic exp_conflict;
        logic sat;
        int   cnt;
        exp_all_sat  = 1'b1;
        exp_conflict = 1'b0;
        for (int c = 0; c < NUM_CLAUSES; c++) begin
            eval_clause(model_cl[c], model_vars, sat, cnt);
            exp_all_sat = exp_all_sat & sat;
            if (!sat && cnt == 0) begin
                exp_conflict = 1'b1;
            end
        end
        check_hex("all_sat_o", 32'(all_sat_o), 32'(exp_all_sat));
        check_hex("conflict_o", 32'(conflict_o), 32'(exp_conflict));
        check_hex("var_vec_o", 32'(var_vec_o), 32'(model_vars));
    endtask

    task automatic check_lengths();
        logic [CLEN_W-1:0] exp;
        for (int c = 0; c < NUM_CLAUSES; c++) begin
            exp = model_reason[c] ? '0 : model_len[c];
            check_hex($sformatf("clause_len_o[%0d]", c), 32'(clause_len_o[c]), 32'(exp));
        end
    endtask

    task automatic do_reset();
        @(posedge clk);
        rst <= 1'b0;
        repeat (5) @(posedge clk);
        rst <= 1'b1;
        model_vars = '0;
        for (int c = 0; c < NUM_CLAUSES; c++) begin
            model_cl[c]     = '0;
            model_len[c]    = '0;
            model_reason[c] = 1'b0;
        end
    endtask

    task automatic write_clause(input int c, input clause_t cl);
        @(posedge clk);
        clause_wr_i  <= NUM_CLAUSES'(1) << c;
        clause_i     <= cl;
        clause_len_i <= lit_count(cl);
        @(posedge clk);
        clause_wr_i  <= '0;
        model_cl[c]  = cl;
        model_len[c] = lit_count(cl);
    endtask

    task automatic decide(input logic [VAR_W-1:0] v, input logic val);
        @(posedge clk);
        dec_wr_i  <= 1'b1;
        dec_var_i <= v;
        dec_val_i <= val;
        @(posedge clk);
        dec_wr_i  <= 1'b0;
        model_vars[v] = '{assigned: 1'b1, value: val, implied: 1'b0};
        @(negedge clk);
    endtask

    task automatic pulse_apply();
        var_vec_t req;
        logic     sat;
        int       cnt;
        @(posedge clk);
        apply_impl_i <= 1'b1;
        @(posedge clk);
        apply_impl_i <= 1'b0;
        req = model_requests(model_vars);
        for (int c = 0; c < NUM_CLAUSES; c++) begin
            eval_clause(model_cl[c], model_vars, sat, cnt);
            if (!sat && cnt == 1) begin
                model_reason[c] = 1'b1;
            end
        end
        for (int v = 0; v < NUM_VARS; v++) begin
            if (req[v].assigned && !model_vars[v].assigned) begin
                model_vars[v] = req[v];
            end
        end
        @(negedge clk);
    endtask

    task automatic pulse_bkt();
        @(posedge clk);
        apply_bkt_i <= 1'b1;
        @(posedge clk);
        apply_bkt_i <= 1'b0;
        for (int v = 0; v < NUM_VARS; v++) begin
            if (model_vars[v].implied) begin
                model_vars[v] = '0;
            end
        end
        @(negedge clk);
    endtask

    task automatic end_test(input string name);
        tests_done++;
        if (errors == err_base) begin
            $display("test %0d %s: ok", tests_done, name);
        end else begin
            $display("test %0d %s: %0d errors", tests_done, name, errors - err_base);
        end
        err_base = errors;
    endtask

    task automatic test_load_readback();
        logic [31:0] r;
        do_reset();
        for (int c = 0; c < NUM_CLAUSES; c++) begin
            next_rand(r);
            write_clause(c, random_clause(r));
        end
        for (int c = 0; c < NUM_CLAUSES; c++) begin
            @(posedge clk);
            clause_rd_i <= NUM_CLAUSES'(1) << c;
            @(negedge clk);
            check_hex($sformatf("clause_o[%0d]", c), 32'(clause_o), 32'(model_cl[c]));
        end
        @(posedge clk);
        clause_rd_i <= '0;
        @(negedge clk);
        check_hex("clause_o", 32'(clause_o), 32'h0);
        check_lengths();
        end_test("load_readback");
    endtask

    task automatic test_random_sat();
        logic [31:0] r;
        for (int round = 0; round < RAND_ROUNDS; round++) begin
            do_reset();
            for (int c = 0; c < NUM_CLAUSES; c++) begin
                next_rand(r);
                write_clause(c, random_clause(r));
            end
            repeat (RAND_DECS) begin
                next_rand(r);
                decide(r[VAR_W-1:0], r[VAR_W]);
                check_state();
            end
        end
        end_test("random_satisfaction");
    endtask

    task automatic test_conflict();
        do_reset();
        write_clause(0, make_clause(8'h01, 8'h02));
        write_clause(1, make_clause(8'h0c, 8'h00));
        write_clause(2, make_clause(8'h30, 8'h00));
        write_clause(3, make_clause(8'h80, 8'h40));
        @(negedge clk);
        check_state();
        check_hex("conflict_o", 32'(conflict_o), 32'h0);
        // x0 = 0 and x1 = 1 make every literal of clause 0 false.
        decide(3'd0, 1'b0);
        decide(3'd1, 1'b1);
        check_state();
        check_hex("conflict_o", 32'(conflict_o), 32'h1);
        end_test("conflict");
    endtask

    task automatic test_unit_prop();
        do_reset();
        write_clause(0, make_clause(8'h03, 8'h04));
        write_clause(1, make_clause(8'h18, 8'h00));
        write_clause(2, make_clause(8'h60, 8'h00));
        write_clause(3, make_clause(8'h20, 8'h80));
        decide(3'd0, 1'b0);
        decide(3'd1, 1'b0);
        check_state();
        pulse_apply();
        check_state();
        // x2 implied false with assigned and implied set.
        check_hex("var_vec_o[2]", 32'(var_vec_o[2]), 32'h5);
        end_test("unit_propagation");
    endtask

    task automatic test_reason_len();
        check_lengths();
        check_hex("clause_len_o[0]", 32'(clause_len_o[0]), 32'h0);
        check_hex("clause_len_o[1]", 32'(clause_len_o[1]), 32'h2);
        end_test("reason_length");
    endtask

    task automatic test_backtrack();
        pulse_bkt();
        check_state();
        check_lengths();
        check_hex("var_vec_o[2]", 32'(var_vec_o[2]), 32'h0);
        pulse_bkt();
        model_reason[0] = 1'b0;
        check_state();
        check_lengths();
        check_hex("clause_len_o[0]", 32'(clause_len_o[0]), 32'h3);
        end_test("backtrack");
    endtask

    initial begin
        rst          = 1'b0;
        clause_wr_i  = '0;
        clause_rd_i  = '0;
        clause_i     = '0;
        clause_len_i = '0;
        dec_wr_i     = 1'b0;
        dec_var_i    = '0;
        dec_val_i    = 1'b0;
        apply_impl_i = 1'b0;
        apply_bkt_i  = 1'b0;
        rng          = 32'hd02e;
        checks       = 0;
        errors       = 0;
        tests_done   = 0;
        err_base     = 0;

        test_load_readback();
        test_random_sat();
        test_conflict();
        test_unit_prop();
        test_reason_len();
        test_backtrack();

        $display("tests %0d, checks %0d, errors %0d", tests_done, checks, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// ==== filelist.f ====
hw/sat_pkg.sv
hw/lit_cell.sv
hw/lit_row.sv
hw/terminal_cell.sv
hw/clause_cell.sv
hw/clause_array.sv
hw/var_store.sv
hw/sat_bcp_top.sv
tb/tb_sat_bcp.sv

// ==== Makefile ====
SIM      := verilator
SIMFLAGS := --binary --timing --assert -j 0
TOP      := tb_sat_bcp
FILELIST := filelist.f
BUILD    := obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator, run it and check the result"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(SIM) $(SIMFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	@out="$$(./$(BUILD)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TB PASSED"

clean:
	rm -rf $(BUILD)
